//--- verilog/riscv_isa_pkg.sv
// RV32I instruction-level definitions shared by the issue stage.
// Covers the raw instruction word, the major opcodes and the immediate formats.
package riscv_isa_pkg;

  // --------------------------------------------------------------------------
  // widths
  // --------------------------------------------------------------------------
  // data and address width
  localparam int unsigned XLEN = 32;
  // architectural register index
  localparam int unsigned REG_IDX_LEN = 5;

  // --------------------------------------------------------------------------
  // instruction word
  // --------------------------------------------------------------------------
  // R-type view, other formats are sliced from the raw bits by the decoder
  typedef struct packed {
    logic [6:0]             funct7;
    logic [REG_IDX_LEN-1:0] rs2;
    logic [REG_IDX_LEN-1:0] rs1;
    logic [2:0]             funct3;
    logic [REG_IDX_LEN-1:0] rd;
    logic [6:0]             opcode;
  } instr_t;

  // major opcodes handled by the issue stage, all others are illegal
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opcode_e;

  // --------------------------------------------------------------------------
  // immediate formats
  // --------------------------------------------------------------------------
  // IMM_NONE yields a zero immediate
  typedef enum logic [2:0] {
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J,
    IMM_NONE
  } imm_format_e;

endpackage

//--- verilog/issue_pipe_pkg.sv
// Pipeline-level types of the issue stage: execution units, the held entry,
// operands and the bundles sent to the execution units and the ROB.
package issue_pipe_pkg;

  import riscv_isa_pkg::*;

  // number of execution units behind the issue stage
  localparam int unsigned NUM_EU = 3;
  // ROB has 2**ROB_IDX_LEN entries
  localparam int unsigned ROB_IDX_LEN = 3;

  typedef logic [ROB_IDX_LEN-1:0] rob_idx_t;

  // execution unit selector, also the bit position in ex_valid_o
  typedef enum logic [1:0] {
    EU_ALU    = 2'd0,
    EU_BRANCH = 2'd1,
    EU_LSU    = 2'd2
  } eu_e;

  // --------------------------------------------------------------------------
  // decoded instruction, as held in the issue register
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [XLEN-1:0]        pc;
    instr_t                 instr;
    eu_e                    eu;
    // completes at issue without any execution unit
    logic                   skip;
    logic                   rs1_req;
    logic                   rs1_is_pc;
    logic                   rs2_req;
    logic                   rs2_is_imm;
    logic [REG_IDX_LEN-1:0] rs1_idx;
    logic [REG_IDX_LEN-1:0] rs2_idx;
    logic [REG_IDX_LEN-1:0] rd_idx;
    logic                   rd_upd;
    logic [XLEN-1:0]        imm;
    logic                   except_raised;
  } issue_entry_t;

  // register status answer for one source register
  typedef struct packed {
    logic     busy;
    rob_idx_t rob_idx;
  } reg_status_t;

  // one source operand, rob_idx names the producer while ready is low
  typedef struct packed {
    logic            ready;
    rob_idx_t        rob_idx;
    logic [XLEN-1:0] value;
  } operand_t;

  // --------------------------------------------------------------------------
  // outgoing bundles
  // --------------------------------------------------------------------------
  typedef struct packed {
    operand_t        rs1;
    operand_t        rs2;
    logic [XLEN-1:0] imm;
    rob_idx_t        rob_idx;
    logic [XLEN-1:0] pc;
  } dispatch_t;

  typedef struct packed {
    instr_t                 instr;
    logic [XLEN-1:0]        pc;
    logic                   res_ready;
    logic [XLEN-1:0]        res_value;
    logic [REG_IDX_LEN-1:0] rd_idx;
    logic                   rd_upd;
    logic                   except_raised;
  } rob_entry_t;

endpackage

//--- verilog/issue_queue.sv
// Circular FIFO between fetch and decode, valid/ready on the push side.
// The head is always visible; pop_i removes it. flush_i empties the queue.
`timescale 1ns/100ps

module issue_queue import riscv_isa_pkg::*; #(
  parameter int unsigned QUEUE_DEPTH = 4
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            flush_i,
  input  logic            push_valid_i,
  output logic            push_ready_o,
  input  logic [XLEN-1:0] push_pc_i,
  input  instr_t          push_instr_i,
  input  logic            pop_i,
  output logic            head_valid_o,
  output logic [XLEN-1:0] head_pc_o,
  output instr_t          head_instr_o
);

  localparam int unsigned PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(QUEUE_DEPTH + 1);

  typedef struct packed {
    logic [XLEN-1:0] pc;
    instr_t          instr;
  } slot_t;

  slot_t             mem_q [QUEUE_DEPTH];
  logic [PTR_W-1:0]  rd_ptr_q, wr_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic              push;

  // a full queue still takes a push when the head leaves in the same cycle
  assign push_ready_o = (count_q != CNT_W'(QUEUE_DEPTH)) | pop_i;
  assign push         = push_valid_i & push_ready_o;
  assign head_valid_o = (count_q != '0);
  assign head_pc_o    = mem_q[rd_ptr_q].pc;
  assign head_instr_o = mem_q[rd_ptr_q].instr;

  // pointers and occupancy
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop_i);
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= '{pc: push_pc_i, instr: push_instr_i};
    end
  end

  // issue_ctrl only pops a head it has seen valid
  a_no_pop_empty : assert property (
    @(posedge clk_i) disable iff (!rst_ni) pop_i |-> head_valid_o
  );

endmodule

//--- verilog/issue_decoder.sv
// Combinational RV32I decoder for the queue head.
// Picks the execution unit and operand sources and builds the immediate.
`timescale 1ns/100ps

module issue_decoder import riscv_isa_pkg::*, issue_pipe_pkg::*; (
  input  logic [XLEN-1:0] pc_i,
  input  instr_t          instr_i,
  output issue_entry_t    entry_o
);

  logic [31:0]     raw;
  imm_format_e     imm_fmt;
  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign raw = instr_i;

  // --------------------------------------------------------------------------
  // immediates, sign extended from bit 31
  // --------------------------------------------------------------------------
  assign imm_i = {{20{raw[31]}}, raw[31:20]};
  assign imm_s = {{20{raw[31]}}, raw[31:25], raw[11:7]};
  assign imm_b = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
  assign imm_u = {raw[31:12], 12'b0};
  assign imm_j = {{11{raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};

  // --------------------------------------------------------------------------
  // opcode classification
  // --------------------------------------------------------------------------
  always_comb begin
    entry_o               = '0;
    entry_o.pc            = pc_i;
    entry_o.instr         = instr_i;
    entry_o.eu            = EU_ALU;
    entry_o.rs1_idx       = instr_i.rs1;
    entry_o.rs2_idx       = instr_i.rs2;
    entry_o.rd_idx        = instr_i.rd;
    entry_o.rd_upd        = 1'b1;
    imm_fmt               = IMM_NONE;
    case (instr_i.opcode)
      OP: begin
        entry_o.rs1_req = 1'b1;
        entry_o.rs2_req = 1'b1;
      end
      OP_IMM: begin
        entry_o.rs1_req    = 1'b1;
        entry_o.rs2_is_imm = 1'b1;
        imm_fmt            = IMM_I;
      end
      // result is the immediate itself, written at issue
      LUI: begin
        entry_o.skip       = 1'b1;
        entry_o.rs2_is_imm = 1'b1;
        imm_fmt            = IMM_U;
      end
      AUIPC: begin
        entry_o.rs1_is_pc  = 1'b1;
        entry_o.rs2_is_imm = 1'b1;
        imm_fmt            = IMM_U;
      end
      // link address computed by the branch unit from pc
      JAL: begin
        entry_o.eu        = EU_BRANCH;
        entry_o.rs1_is_pc = 1'b1;
        imm_fmt           = IMM_J;
      end
      BRANCH: begin
        entry_o.eu      = EU_BRANCH;
        entry_o.rs1_req = 1'b1;
        entry_o.rs2_req = 1'b1;
        entry_o.rd_upd  = 1'b0;
        imm_fmt         = IMM_B;
      end
      LOAD: begin
        entry_o.eu      = EU_LSU;
        entry_o.rs1_req = 1'b1;
        imm_fmt         = IMM_I;
      end
      STORE: begin
        entry_o.eu      = EU_LSU;
        entry_o.rs1_req = 1'b1;
        entry_o.rs2_req = 1'b1;
        entry_o.rd_upd  = 1'b0;
        imm_fmt         = IMM_S;
      end
      // illegal instruction goes straight to the ROB as an exception
      default: begin
        entry_o.skip          = 1'b1;
        entry_o.rd_upd        = 1'b0;
        entry_o.except_raised = 1'b1;
      end
    endcase
    case (imm_fmt)
      IMM_I:   entry_o.imm = imm_i;
      IMM_S:   entry_o.imm = imm_s;
      IMM_B:   entry_o.imm = imm_b;
      IMM_U:   entry_o.imm = imm_u;
      IMM_J:   entry_o.imm = imm_j;
      default: entry_o.imm = '0;
    endcase
  end

endmodule

//--- verilog/operand_fetch.sv
// Combinational operand selection for the instruction in the issue register.
// Sources: pc or immediate, commit-stage forward, or the register file.
`timescale 1ns/100ps

module operand_fetch import riscv_isa_pkg::*, issue_pipe_pkg::*; (
  input  issue_entry_t    entry_i,
  input  reg_status_t     rs1_stat_i,
  input  reg_status_t     rs2_stat_i,
  input  logic [XLEN-1:0] rs1_rf_i,
  input  logic [XLEN-1:0] rs2_rf_i,
  input  logic            rs1_fwd_ready_i,
  input  logic [XLEN-1:0] rs1_fwd_i,
  input  logic            rs2_fwd_ready_i,
  input  logic [XLEN-1:0] rs2_fwd_i,
  output operand_t        rs1_o,
  output operand_t        rs2_o
);

  // one source, highest priority first
  function automatic operand_t pick(input logic            use_special,
                                    input logic [XLEN-1:0] special_val,
                                    input logic            req,
                                    input reg_status_t     stat,
                                    input logic            fwd_ready,
                                    input logic [XLEN-1:0] fwd_val,
                                    input logic [XLEN-1:0] rf_val);
    operand_t op;
    op.ready   = 1'b1;
    op.rob_idx = stat.rob_idx;
    op.value   = '0;
    if (use_special) begin
      op.value = special_val;
    end else if (req && stat.busy) begin
      // producer still in flight, wait for the ROB unless it has the value
      op.ready = fwd_ready;
      op.value = fwd_ready ? fwd_val : '0;
    end else if (req) begin
      op.value = rf_val;
    end
    return op;
  endfunction

  assign rs1_o = pick(entry_i.rs1_is_pc, entry_i.pc, entry_i.rs1_req, rs1_stat_i,
                      rs1_fwd_ready_i, rs1_fwd_i, rs1_rf_i);
  assign rs2_o = pick(entry_i.rs2_is_imm, entry_i.imm, entry_i.rs2_req, rs2_stat_i,
                      rs2_fwd_ready_i, rs2_fwd_i, rs2_rf_i);

endmodule

//--- verilog/issue_ctrl.sv
// Issue register and firing control.
// Loads the decoded head, fires it to one unit and the ROB in the same cycle.
`timescale 1ns/100ps

module issue_ctrl import riscv_isa_pkg::*, issue_pipe_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               flush_i,
  input  logic               head_valid_i,
  output logic               pop_o,
  input  issue_entry_t       entry_i,
  output issue_entry_t       held_o,
  input  operand_t           rs1_i,
  input  operand_t           rs2_i,
  input  logic [NUM_EU-1:0]  ex_ready_i,
  output logic [NUM_EU-1:0]  ex_valid_o,
  output dispatch_t          dispatch_o,
  input  logic               comm_ready_i,
  input  rob_idx_t           comm_tail_idx_i,
  output logic               comm_valid_o,
  output rob_entry_t         comm_data_o
);

  issue_entry_t       entry_q;
  logic               valid_q;
  logic [NUM_EU-1:0]  unit_sel;
  logic               fire, load;

  // --------------------------------------------------------------------------
  // firing rule
  // --------------------------------------------------------------------------
  always_comb begin
    unit_sel              = '0;
    unit_sel[entry_q.eu]  = 1'b1;
  end

  // skipping instructions only need a free ROB slot
  assign fire  = valid_q & comm_ready_i & ~flush_i &
                 (entry_q.skip | (|(unit_sel & ex_ready_i)));
  assign load  = head_valid_i & (~valid_q | fire);
  assign pop_o = load;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (fire) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      entry_q <= entry_i;
    end
  end

  // --------------------------------------------------------------------------
  // outputs
  // --------------------------------------------------------------------------
  assign held_o       = entry_q;
  assign ex_valid_o   = (fire && !entry_q.skip) ? unit_sel : '0;
  assign comm_valid_o = fire;

  // the unit gets the ROB slot allocated in this same cycle
  assign dispatch_o = '{rs1: rs1_i, rs2: rs2_i, imm: entry_q.imm,
                        rob_idx: comm_tail_idx_i, pc: entry_q.pc};

  assign comm_data_o = '{instr: entry_q.instr, pc: entry_q.pc,
                         res_ready: entry_q.skip, res_value: entry_q.imm,
                         rd_idx: entry_q.rd_idx, rd_upd: entry_q.rd_upd,
                         except_raised: entry_q.except_raised};

  a_ex_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_ni) $onehot0(ex_valid_o)
  );
  // every dispatch also allocates a ROB entry
  a_ex_with_comm : assert property (
    @(posedge clk_i) disable iff (!rst_ni) (|ex_valid_o) |-> comm_valid_o
  );

endmodule

//--- verilog/issue_stage.sv
// Issue stage top level: queue, decoder, operand fetch and issue control.
`timescale 1ns/100ps

module issue_stage import riscv_isa_pkg::*, issue_pipe_pkg::*; #(
  parameter int unsigned QUEUE_DEPTH = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  // fetch
  input  logic                   fetch_valid_i,
  output logic                   fetch_ready_o,
  input  logic [XLEN-1:0]        fetch_pc_i,
  input  instr_t                 fetch_instr_i,
  // register status and register file
  output logic [REG_IDX_LEN-1:0] rs1_idx_o,
  output logic [REG_IDX_LEN-1:0] rs2_idx_o,
  input  reg_status_t            rs1_stat_i,
  input  reg_status_t            rs2_stat_i,
  input  logic [XLEN-1:0]        rs1_rf_i,
  input  logic [XLEN-1:0]        rs2_rf_i,
  // commit-stage forwarding
  output rob_idx_t               rs1_rob_idx_o,
  output rob_idx_t               rs2_rob_idx_o,
  input  logic                   rs1_fwd_ready_i,
  input  logic [XLEN-1:0]        rs1_fwd_i,
  input  logic                   rs2_fwd_ready_i,
  input  logic [XLEN-1:0]        rs2_fwd_i,
  // execution units and ROB
  input  logic [NUM_EU-1:0]      ex_ready_i,
  output logic [NUM_EU-1:0]      ex_valid_o,
  output dispatch_t              dispatch_o,
  input  logic                   comm_ready_i,
  input  rob_idx_t               comm_tail_idx_i,
  output logic                   comm_valid_o,
  output rob_entry_t             comm_data_o
);

  logic            head_valid, pop;
  logic [XLEN-1:0] head_pc;
  instr_t          head_instr;
  issue_entry_t    dec_entry, held;
  operand_t        rs1_op, rs2_op;

  assign rs1_idx_o     = held.rs1_idx;
  assign rs2_idx_o     = held.rs2_idx;
  assign rs1_rob_idx_o = rs1_op.rob_idx;
  assign rs2_rob_idx_o = rs2_op.rob_idx;

  issue_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) issue_queue_inst (
    .clk_i, .rst_ni, .flush_i,
    .push_valid_i(fetch_valid_i), .push_ready_o(fetch_ready_o),
    .push_pc_i(fetch_pc_i), .push_instr_i(fetch_instr_i), .pop_i(pop),
    .head_valid_o(head_valid), .head_pc_o(head_pc), .head_instr_o(head_instr)
  );

  issue_decoder issue_decoder_inst (.pc_i(head_pc), .instr_i(head_instr), .entry_o(dec_entry));

  // works on the held instruction, beside the decoder on the head
  operand_fetch operand_fetch_inst (
    .entry_i(held), .rs1_stat_i, .rs2_stat_i, .rs1_rf_i, .rs2_rf_i,
    .rs1_fwd_ready_i, .rs1_fwd_i, .rs2_fwd_ready_i, .rs2_fwd_i,
    .rs1_o(rs1_op), .rs2_o(rs2_op)
  );

  issue_ctrl issue_ctrl_inst (
    .clk_i, .rst_ni, .flush_i, .head_valid_i(head_valid), .pop_o(pop),
    .entry_i(dec_entry), .held_o(held), .rs1_i(rs1_op), .rs2_i(rs2_op),
    .ex_ready_i, .ex_valid_o, .dispatch_o,
    .comm_ready_i, .comm_tail_idx_i, .comm_valid_o, .comm_data_o
  );

endmodule

//--- dv/tb_issue_stage.sv
// Testbench for the issue stage: directed, random and flush traffic against a
// scoreboard model of decode and operand selection, checked by assertions.
`timescale 1ns/100ps

module tb_issue_stage
  import riscv_isa_pkg::*, issue_pipe_pkg::*;
();

  localparam int CLK_PERIOD   = 40;
  localparam int QUEUE_DEPTH  = 4;
  localparam int NUM_DIRECTED = 10;
  localparam int NUM_RANDOM   = 300;
  // directed list runs twice, plus the batch that gets flushed
  localparam int NUM_SENT     = 2 * NUM_DIRECTED + NUM_RANDOM + QUEUE_DEPTH + 1;
  localparam int SB_SIZE      = 512;

  // operand source codes of the model
  localparam logic [1:0] SRC_NONE    = 2'd0;
  localparam logic [1:0] SRC_SPECIAL = 2'd1;
  localparam logic [1:0] SRC_REG     = 2'd2;

  localparam logic [31:0] DIRECTED [NUM_DIRECTED] = '{
    32'h0020_81b3,  // add   x3, x1, x2
    32'hfff3_0293,  // addi  x5, x6, -1
    32'hfe71_2c23,  // sw    x7, -8(x2)
    32'hfe20_88e3,  // beq   x1, x2, -16
    32'h1234_5537,  // lui   x10, 0x12345
    32'hffff_f597,  // auipc x11, 0xfffff
    32'hffdf_f0ef,  // jal   x1, -4
    32'h7ff6_a603,  // lw    x12, 0x7ff(x13)
    32'h0000_000f,  // fence, not part of this subset
    32'hffff_ffff   // no valid opcode at all
  };

  // expected view of one accepted instruction
  typedef struct packed {
    rob_entry_t        rob;
    logic [NUM_EU-1:0] ex;
    logic [1:0]        rs1_src;
    logic [1:0]        rs2_src;
    logic [XLEN-1:0]   imm;
  } expect_t;

  logic                   clk_i = 1'b0;
  logic                   rst_ni;
  logic                   flush_i;
  logic                   fetch_valid_i;
  logic                   fetch_ready_o;
  logic [XLEN-1:0]        fetch_pc_i;
  instr_t                 fetch_instr_i;
  logic [REG_IDX_LEN-1:0] rs1_idx_o;
  logic [REG_IDX_LEN-1:0] rs2_idx_o;
  reg_status_t            rs1_stat_i = '0;
  reg_status_t            rs2_stat_i = '0;
  logic [XLEN-1:0]        rs1_rf_i;
  logic [XLEN-1:0]        rs2_rf_i;
  rob_idx_t               rs1_rob_idx_o;
  rob_idx_t               rs2_rob_idx_o;
  logic                   rs1_fwd_ready_i = 1'b0;
  logic [XLEN-1:0]        rs1_fwd_i;
  logic                   rs2_fwd_ready_i = 1'b0;
  logic [XLEN-1:0]        rs2_fwd_i;
  logic [NUM_EU-1:0]      ex_ready_i = '1;
  logic [NUM_EU-1:0]      ex_valid_o;
  dispatch_t              dispatch_o;
  logic                   comm_ready_i = 1'b1;
  rob_idx_t               comm_tail_idx_i = '0;
  logic                   comm_valid_o;
  rob_entry_t             comm_data_o;

  // stimulus control, random state and scoreboard
  logic            stress    = 1'b0;
  logic            hold_rob  = 1'b0;
  logic [31:0]     ready_rng = 32'd84;
  logic [31:0]     instr_rng = 32'd84;
  logic [XLEN-1:0] next_pc   = 32'h0000_1000;
  expect_t         sb_mem [SB_SIZE];
  int              sb_wr, sb_rd, outstanding;
  expect_t         exp_head;
  dispatch_t       exp_disp;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  issue_stage #(.QUEUE_DEPTH(QUEUE_DEPTH)) issue_stage_inst (.*);

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // register file model, x0 reads zero by construction
  function automatic logic [XLEN-1:0] rf_value(input logic [REG_IDX_LEN-1:0] idx);
    return XLEN'(idx) * 32'h0101_0101;
  endfunction

  // decode rules of the issue stage, per RV32I major opcode
  function automatic expect_t predict(input logic [XLEN-1:0] pc, input logic [31:0] w);
    expect_t         e;
    logic            skip;
    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    imm_i = 32'($signed(w[31:20]));
    imm_s = 32'($signed({w[31:25], w[11:7]}));
    imm_b = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
    imm_u = {w[31:12], 12'h000};
    imm_j = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
    e = '0;
    e.rs1_src = SRC_NONE;
    e.rs2_src = SRC_NONE;
    skip = 1'b0;
    e.rob.rd_upd = 1'b1;
    case (w[6:0])
      OP: begin
        e.ex      = 3'b001;
        e.rs1_src = SRC_REG;
        e.rs2_src = SRC_REG;
      end
      OP_IMM: begin
        e.ex      = 3'b001;
        e.rs1_src = SRC_REG;
        e.rs2_src = SRC_SPECIAL;
        e.imm     = imm_i;
      end
      LUI: begin
        skip      = 1'b1;
        e.rs2_src = SRC_SPECIAL;
        e.imm     = imm_u;
      end
      AUIPC: begin
        e.ex      = 3'b001;
        e.rs1_src = SRC_SPECIAL;
        e.rs2_src = SRC_SPECIAL;
        e.imm     = imm_u;
      end
      JAL: begin
        e.ex      = 3'b010;
        e.rs1_src = SRC_SPECIAL;
        e.imm     = imm_j;
      end
      BRANCH: begin
        e.ex         = 3'b010;
        e.rs1_src    = SRC_REG;
        e.rs2_src    = SRC_REG;
        e.rob.rd_upd = 1'b0;
        e.imm        = imm_b;
      end
      LOAD: begin
        e.ex      = 3'b100;
        e.rs1_src = SRC_REG;
        e.imm     = imm_i;
      end
      STORE: begin
        e.ex         = 3'b100;
        e.rs1_src    = SRC_REG;
        e.rs2_src    = SRC_REG;
        e.rob.rd_upd = 1'b0;
        e.imm        = imm_s;
      end
      default: begin
        skip                = 1'b1;
        e.rob.rd_upd        = 1'b0;
        e.rob.except_raised = 1'b1;
      end
    endcase
    e.rob.instr     = w;
    e.rob.pc        = pc;
    e.rob.res_ready = skip;
    e.rob.res_value = e.imm;
    e.rob.rd_idx    = w[11:7];
    return e;
  endfunction

  // pc or immediate first, then forward or stall on busy, then register file
  function automatic operand_t expected_operand(input logic [1:0]             src,
                                                input logic [XLEN-1:0]        special,
                                                input logic [REG_IDX_LEN-1:0] idx,
                                                input reg_status_t            stat,
                                                input logic                   fwd_ready);
    operand_t o;
    o.ready   = 1'b1;
    o.rob_idx = stat.rob_idx;
    o.value   = '0;
    if (src == SRC_SPECIAL) begin
      o.value = special;
    end else if (src == SRC_REG && !stat.busy) begin
      o.value = rf_value(idx);
    end else if (src == SRC_REG && fwd_ready) begin
      o.value = rf_value(idx) + 32'h100;
    end else if (src == SRC_REG) begin
      o.ready = 1'b0;
    end
    return o;
  endfunction

  function automatic logic [31:0] random_instr(input logic [31:0] r);
    logic [6:0] op;
    case (r[3:0])
      4'd0: op = OP_IMM;
      4'd1: op = LUI;
      4'd2: op = AUIPC;
      4'd3: op = JAL;
      4'd4: op = BRANCH;
      4'd5: op = LOAD;
      4'd6: op = STORE;
      4'd7: op = OP_IMM;
      // system and misc-mem, both illegal here
      4'd8: op = 7'h73;
      4'd9: op = 7'h0f;
      default: op = OP;
    endcase
    return {r[31:7], op};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [191:0] got,
                                 input logic [191:0] exp);
    abort_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  // one fetch handshake, returns on the edge where it was accepted
  task automatic send_instr(input logic [31:0] w);
    fetch_valid_i <= 1'b1;
    fetch_pc_i    <= next_pc;
    fetch_instr_i <= w;
    next_pc = next_pc + 32'd4;
    @(posedge clk_i);
    while (!fetch_ready_o) begin
      @(posedge clk_i);
    end
    fetch_valid_i <= 1'b0;
  endtask

  task automatic send_directed();
    for (int i = 0; i < NUM_DIRECTED; i++) begin
      send_instr(DIRECTED[i]);
    end
  endtask

  task automatic drain();
    while (outstanding != 0) begin
      @(posedge clk_i);
    end
  endtask

  // --------------------------------------------------------------------------
  // neighbouring stage models
  // --------------------------------------------------------------------------
  assign rs1_rf_i  = rf_value(rs1_idx_o);
  assign rs2_rf_i  = rf_value(rs2_idx_o);
  assign rs1_fwd_i = rs1_rf_i + 32'h100;
  assign rs2_fwd_i = rs2_rf_i + 32'h100;

  // readiness, busy bits and the ROB tail, new every cycle
  always @(posedge clk_i) begin
    ready_rng = xorshift(ready_rng);
    ex_ready_i      <= stress ? (ready_rng[2:0] | ready_rng[5:3]) : '1;
    comm_ready_i    <= ~hold_rob & (~stress | ready_rng[6] | ready_rng[7]);
    rs1_stat_i      <= '{busy: stress & ready_rng[8], rob_idx: ready_rng[11:9]};
    rs2_stat_i      <= '{busy: stress & ready_rng[12], rob_idx: ready_rng[15:13]};
    rs1_fwd_ready_i <= ready_rng[16];
    rs2_fwd_ready_i <= ready_rng[17];
    comm_tail_idx_i <= ready_rng[20:18];
  end

  // scoreboard, a flush drops everything accepted so far
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sb_wr <= 0;
      sb_rd <= 0;
    end else if (flush_i) begin
      sb_rd <= sb_wr;
    end else begin
      if (comm_valid_o) begin
        sb_rd <= sb_rd + 1;
      end
      if (fetch_valid_i && fetch_ready_o) begin
        sb_mem[sb_wr] <= predict(fetch_pc_i, fetch_instr_i);
        sb_wr         <= sb_wr + 1;
      end
    end
  end

  assign outstanding = sb_wr - sb_rd;
  assign exp_head    = sb_mem[sb_rd];
  assign exp_disp    = '{
    rs1: expected_operand(exp_head.rs1_src, exp_head.rob.pc, exp_head.rob.instr.rs1,
                          rs1_stat_i, rs1_fwd_ready_i),
    rs2: expected_operand(exp_head.rs2_src, exp_head.imm, exp_head.rob.instr.rs2,
                          rs2_stat_i, rs2_fwd_ready_i),
    imm: exp_head.imm, rob_idx: comm_tail_idx_i, pc: exp_head.rob.pc
  };

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------
  a_fire_in_order : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (comm_valid_o || ex_valid_o != '0) |-> outstanding != 0)
    else abort_run("an instruction fired although none was outstanding");

  a_rob_entry : assert property (@(posedge clk_i) disable iff (!rst_ni)
    comm_valid_o |-> comm_data_o == exp_head.rob)
    else report_mismatch("comm_data_o", $sampled(comm_data_o), $sampled(exp_head.rob));

  a_unit_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    comm_valid_o |-> ex_valid_o == exp_head.ex)
    else report_mismatch("ex_valid_o", $sampled(ex_valid_o), $sampled(exp_head.ex));

  a_dispatch : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|ex_valid_o) |-> dispatch_o == exp_disp)
    else report_mismatch("dispatch_o", $sampled(dispatch_o), $sampled(exp_disp));

  // producer indices go out to the commit side as given by register status
  a_fwd_idx : assert property (@(posedge clk_i) disable iff (!rst_ni)
    {rs1_rob_idx_o, rs2_rob_idx_o} == {rs1_stat_i.rob_idx, rs2_stat_i.rob_idx})
    else report_mismatch("{rs1_rob_idx_o, rs2_rob_idx_o}",
                         {$sampled(rs1_rob_idx_o), $sampled(rs2_rob_idx_o)},
                         {$sampled(rs1_stat_i.rob_idx), $sampled(rs2_stat_i.rob_idx)});

  // queue plus issue register is the whole capacity
  a_fetch_ready : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !fetch_ready_o |-> outstanding == QUEUE_DEPTH + 1)
    else report_mismatch("outstanding with fetch_ready_o low", $sampled(outstanding),
                         QUEUE_DEPTH + 1);

  a_flush_idle : assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> !comm_valid_o && ex_valid_o == '0 && fetch_ready_o)
    else abort_run("the DUT was not idle and ready on the cycle after a flush");

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  initial begin
    rst_ni        <= 1'b0;
    flush_i       <= 1'b0;
    fetch_valid_i <= 1'b0;
    fetch_pc_i    <= '0;
    fetch_instr_i <= '0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    // all units ready and no busy source
    send_directed();
    drain();
    // random back-pressure, busy sources and forwards
    stress <= 1'b1;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      instr_rng = xorshift(instr_rng);
      send_instr(random_instr(instr_rng));
      if (instr_rng[5:4] == 2'b00) begin
        @(posedge clk_i);
      end
    end
    drain();
    // stalled ROB fills queue and register, then everything is flushed
    stress   <= 1'b0;
    hold_rob <= 1'b1;
    for (int i = 0; i < QUEUE_DEPTH + 1; i++) begin
      send_instr(DIRECTED[i]);
    end
    repeat (4) @(posedge clk_i);
    // ROB opens right behind the flush, so a stale entry would fire
    flush_i  <= 1'b1;
    hold_rob <= 1'b0;
    @(posedge clk_i);
    flush_i <= 1'b0;
    repeat (8) @(posedge clk_i);
    send_directed();
    drain();
    $display("Test completed successfully");
    $finish;
  end

  // run length bound, 200 cycles per instruction sent
  initial begin
    #(NUM_SENT * 200 * CLK_PERIOD);
    abort_run("watchdog expired, instructions were not accepted or never fired");
  end

endmodule

//--- issue_stage.f
verilog/riscv_isa_pkg.sv
verilog/issue_pipe_pkg.sv
verilog/issue_queue.sv
verilog/issue_decoder.sv
verilog/operand_fetch.sv
verilog/issue_ctrl.sv
verilog/issue_stage.sv
dv/tb_issue_stage.sv

//--- Bender.yml
package:
  name: issue_stage

sources:
  # packages first, then the blocks, then the top level
  - verilog/riscv_isa_pkg.sv
  - verilog/issue_pipe_pkg.sv
  - verilog/issue_queue.sv
  - verilog/issue_decoder.sv
  - verilog/operand_fetch.sv
  - verilog/issue_ctrl.sv
  - verilog/issue_stage.sv
  - target: test
    files:
      - dv/tb_issue_stage.sv
